// ==== hw/baud_rate_generator.sv ====
`timescale 1ns/1ps

`include "mips_debug_config.svh"

module baud_rate_generator (
    input  logic i_clock,
    input  logic i_rst,
    output logic o_tick    // One clock wide, 16 per bit.
);

    // Integer divisor, truncated. RX and TX share it.
    localparam int unsigned DIVISOR = `CLK_FREQ_HZ / (`BAUD_RATE * `UART_OVERSAMPLE);
    localparam int unsigned CNT_W   = $clog2(DIVISOR);

    logic [CNT_W-1:0] count;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else begin
            o_tick <= 1'b0;
            if (count == CNT_W'(DIVISOR - 1)) begin
                count  <= '0;    // Wrap and tick.
                o_tick <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== hw/debug_unit.sv ====
`timescale 1ns/1ps

`include "mips_debug_config.svh"

module debug_unit (
    input  logic                        i_clock,
    input  logic                        i_rst,
    input  logic                        i_rx_done,
    input  mips_debug_pkg::byte_t       i_rx_data,
    input  logic                        i_tx_done,
    output logic                        o_tx_start,
    output mips_debug_pkg::byte_t       o_tx_data,
    output mips_debug_pkg::report_sel_e o_report_sel,
    input  mips_debug_pkg::word_t       i_report_word,
    fetch_ctrl_if.ctrl                  ctrl,
    output logic                        o_led_halt
);
    import mips_debug_pkg::*;

    localparam report_sel_e LAST_SEL = report_sel_e'(`REPORT_WORDS - 1);

    dbg_state_e state;
    byte_t      word_count;   // N from the load header.
    byte_t      word_idx;     // Word being loaded.
    logic [1:0] byte_idx;     // Byte within a word, load and report.
    logic       is_halt;
    logic       tx_busy;      // Byte handed to tx, done not back yet.

    assign is_halt = ctrl.instruction[`INSTR_W-1 -: 6] == `HALT_OPCODE;

    // Combinational so a run can advance every clock.
    assign ctrl.enable_pc = (state == ST_RUN || state == ST_STEP) && !is_halt;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state           <= ST_IDLE;
            o_tx_start      <= 1'b0;
            o_led_halt      <= 1'b0;
            o_report_sel    <= SEL_PC;
            byte_idx        <= '0;
            ctrl.soft_reset <= 1'b0;
            ctrl.write_en   <= 1'b0;
        end else begin
            o_tx_start      <= 1'b0;   // Strobes default low.
            ctrl.soft_reset <= 1'b0;
            ctrl.write_en   <= 1'b0;
            case (state)
                ////////////////////////////////////////////////////////////////
                // Command decode.
                ////////////////////////////////////////////////////////////////
                ST_IDLE: if (i_rx_done) begin
                    case (dbg_cmd_e'(i_rx_data))
                        CMD_LOAD: state <= ST_LOAD_COUNT;
                        CMD_RUN:  state <= ST_RUN;
                        CMD_STEP: state <= ST_STEP;
                        CMD_RESET: begin
                            ctrl.soft_reset <= 1'b1;   // No reply.
                            o_led_halt      <= 1'b0;
                        end
                        default: ;                     // Unknown byte ignored.
                    endcase
                end
                ////////////////////////////////////////////////////////////////
                // Program load.
                ////////////////////////////////////////////////////////////////
                ST_LOAD_COUNT: if (i_rx_done) begin
                    word_count <= i_rx_data;
                    word_idx   <= '0;
                    byte_idx   <= '0;
                    state      <= (i_rx_data == '0) ? ST_SOFT_RESET : ST_LOAD_BYTES;
                end
                ST_LOAD_BYTES: if (i_rx_done) begin
                    ctrl.write_data <= {i_rx_data, ctrl.write_data[`INSTR_W-1:8]};  // LSB first.
                    byte_idx        <= byte_idx + 1'b1;
                    if (byte_idx == 2'd3) state <= ST_LOAD_WRITE;
                end
                ST_LOAD_WRITE: begin
                    ctrl.write_en   <= 1'b1;
                    ctrl.write_addr <= pc_t'({word_idx, 2'b00});
                    word_idx        <= word_idx + 1'b1;
                    state <= (word_idx + 8'd1 == word_count) ? ST_SOFT_RESET : ST_LOAD_BYTES;
                end
                ST_SOFT_RESET: begin
                    ctrl.soft_reset <= 1'b1;
                    o_led_halt      <= 1'b0;
                    o_tx_data       <= word_count;    // Reply with N.
                    o_tx_start      <= 1'b1;
                    o_report_sel    <= LAST_SEL;      // Single byte, wait ends at idle.
                    byte_idx        <= 2'd3;
                    state           <= ST_REPORT_WAIT;
                end
                ////////////////////////////////////////////////////////////////
                // Execution.
                ////////////////////////////////////////////////////////////////
                ST_RUN: if (is_halt) begin
                    o_led_halt   <= 1'b1;
                    o_report_sel <= SEL_PC;
                    state        <= ST_REPORT_SEL;
                end
                ST_STEP: begin
                    if (is_halt) o_led_halt <= 1'b1;  // Halt, PC holds.
                    o_report_sel <= SEL_PC;
                    state        <= ST_REPORT_SEL;
                end
                ////////////////////////////////////////////////////////////////
                // Report, 4 words by 4 bytes.
                ////////////////////////////////////////////////////////////////
                ST_REPORT_SEL: state <= ST_REPORT_SEND;   // Status register loads.
                ST_REPORT_SEND: begin
                    o_tx_data  <= i_report_word[byte_idx*8 +: 8];
                    o_tx_start <= 1'b1;
                    state      <= ST_REPORT_WAIT;
                end
                ST_REPORT_WAIT: if (i_tx_done) begin
                    byte_idx <= byte_idx + 1'b1;           // Wraps to 0 after 3.
                    if (byte_idx != 2'd3) begin
                        state <= ST_REPORT_SEND;
                    end else if (o_report_sel == LAST_SEL) begin
                        state <= ST_IDLE;
                    end else begin
                        o_report_sel <= report_sel_e'(o_report_sel + 1'b1);
                        state        <= ST_REPORT_SEL;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Byte in flight, from start until tx reports done.
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            tx_busy <= 1'b0;
        end else if (o_tx_start) begin
            tx_busy <= 1'b1;
        end else if (i_tx_done) begin
            tx_busy <= 1'b0;
        end
    end

    // Each byte needs its own done before another start.
    a_one_byte_in_flight: assert property (@(posedge i_clock) disable iff (i_rst)
        o_tx_start |-> !tx_busy);

endmodule

// ==== hw/fetch_ctrl_if.sv ====
`timescale 1ns/1ps

interface fetch_ctrl_if;
    import mips_debug_pkg::*;

    logic  soft_reset;   // PC and cycle count back to zero.
    logic  enable_pc;    // Advance one instruction.
    logic  write_en;     // Program memory write strobe.
    pc_t   write_addr;   // Byte address of the written word.
    word_t write_data;
    pc_t   pc;           // Current PC.
    word_t instruction;  // Word at pc, registered.

    // Debug unit side. Only the opcode is looked at.
    modport ctrl (output soft_reset, enable_pc, write_en, write_addr, write_data,
                  input instruction);
    // Fetch stage side.
    modport fetch (input soft_reset, enable_pc, write_en, write_addr, write_data,
                   output pc, instruction);
    // Status block, read only.
    modport observe (input soft_reset, enable_pc, pc, instruction);

endinterface

// ==== hw/instruction_fetch.sv ====
`timescale 1ns/1ps

`include "mips_debug_config.svh"

module instruction_fetch (
    input  logic       i_clock,
    input  logic       i_rst,
    fetch_ctrl_if.fetch fetch
);
    import mips_debug_pkg::*;

    localparam int IDX_W = $clog2(`PROG_DEPTH);

    word_t mem [`PROG_DEPTH];    // Program memory, contents set by load.
    pc_t   pc_next;
    logic  update;

    //////////////////////////////////////////////////////////////////////
    // Next PC.
    //////////////////////////////////////////////////////////////////////
    assign update  = fetch.soft_reset || fetch.enable_pc;
    assign pc_next = fetch.soft_reset ? '0 : fetch.pc + pc_t'(4);  // Soft reset wins.

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            fetch.pc <= '0;
        end else if (update) begin
            fetch.pc <= pc_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory. Write port for the loader, read at the new PC.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clock) begin
        if (fetch.write_en) begin
            mem[fetch.write_addr[IDX_W+1:2]] <= fetch.write_data;  // Word index.
        end
    end

    // Instruction tracks pc in the same edge.
    always_ff @(posedge i_clock) begin
        if (update) begin
            fetch.instruction <= mem[pc_next[IDX_W+1:2]];
        end
    end

    // Loader and execution never overlap.
    a_no_write_while_running: assert property (@(posedge i_clock) disable iff (i_rst)
        !(fetch.write_en && fetch.enable_pc));

endmodule

// ==== hw/mips_debug_config.svh ====
`ifndef MIPS_DEBUG_CONFIG_SVH
`define MIPS_DEBUG_CONFIG_SVH

// Clock and serial link.
`define CLK_FREQ_HZ      50000000  // Board clock.
`define BAUD_RATE        115200    // Host link speed.
`define UART_OVERSAMPLE  16        // Ticks per bit.
`define UART_DATA_BITS   8         // Payload bits per frame.
`define UART_STOP_BITS   2         // Stop bits per frame.

// Fetch stage.
`define INSTR_W          32        // Instruction word.
`define PROG_DEPTH       256       // Program memory words.
`define PC_W             10        // Byte address, low two bits always zero.
`define HALT_OPCODE      6'h3f     // Opcode field that stops a run.
`define REPORT_WORDS     4         // Words per debug report.

`endif

// ==== hw/mips_debug_pkg.sv ====
package mips_debug_pkg;

`include "mips_debug_config.svh"

    typedef logic [`INSTR_W-1:0] word_t;  // Instruction and report word.
    typedef logic [`PC_W-1:0]    pc_t;    // Byte address into program memory.
    typedef logic [7:0]          byte_t;  // Serial payload.

    // Host commands, one byte each.
    typedef enum logic [7:0] {
        CMD_LOAD  = 8'h01,
        CMD_RUN   = 8'h02,
        CMD_STEP  = 8'h03,
        CMD_RESET = 8'h04
    } dbg_cmd_e;

    // Debug unit FSM.
    typedef enum logic [3:0] {
        ST_IDLE, ST_LOAD_COUNT, ST_LOAD_BYTES, ST_LOAD_WRITE, ST_SOFT_RESET,
        ST_RUN, ST_STEP, ST_REPORT_SEL, ST_REPORT_SEND, ST_REPORT_WAIT
    } dbg_state_e;

    // Report word order on the wire.
    typedef enum logic [1:0] {
        SEL_PC, SEL_PC_PLUS4, SEL_CYCLES, SEL_INSTR
    } report_sel_e;

endpackage

// ==== hw/mips_debug_top.sv ====
`timescale 1ns/1ps

module mips_debug_top (
    input  logic i_clock,
    input  logic i_rst,
    input  logic i_uart_rx,    // From host.
    output logic o_uart_tx,    // To host.
    output logic o_led_halt
);
    import mips_debug_pkg::*;

    logic        tick;
    logic        rx_done;
    byte_t       rx_data;
    logic        tx_start;
    logic        tx_done;
    byte_t       tx_data;
    report_sel_e report_sel;
    word_t       report_word;

    fetch_ctrl_if u_fetch_bus ();   // Debug unit, fetch and status.

    baud_rate_generator u_baud (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .o_tick  (tick)
    );

    uart_rx u_rx (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_tick    (tick),
        .i_bit_rx  (i_uart_rx),
        .o_rx_done (rx_done),
        .o_data    (rx_data)
    );

    uart_tx u_tx (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_tick     (tick),
        .i_tx_start (tx_start),
        .i_data     (tx_data),
        .o_bit_tx   (o_uart_tx),
        .o_tx_done  (tx_done)
    );

    debug_unit u_debug (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_rx_done     (rx_done),
        .i_rx_data     (rx_data),
        .i_tx_done     (tx_done),
        .o_tx_start    (tx_start),
        .o_tx_data     (tx_data),
        .o_report_sel  (report_sel),
        .i_report_word (report_word),
        .ctrl          (u_fetch_bus.ctrl),
        .o_led_halt    (o_led_halt)
    );

    instruction_fetch u_fetch (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .fetch   (u_fetch_bus.fetch)
    );

    run_status u_status (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .obs     (u_fetch_bus.observe),
        .i_sel   (report_sel),
        .o_word  (report_word)
    );

endmodule

// ==== hw/run_status.sv ====
`timescale 1ns/1ps

module run_status (
    input  logic                        i_clock,
    input  logic                        i_rst,
    fetch_ctrl_if.observe               obs,
    input  mips_debug_pkg::report_sel_e i_sel,
    output mips_debug_pkg::word_t       o_word   // One cycle after i_sel.
);
    import mips_debug_pkg::*;

    word_t cycles;    // Executed instructions since soft reset.
    word_t pc_word;   // PC, zero-extended.

    assign pc_word = word_t'(obs.pc);

    always_ff @(posedge i_clock) begin
        if (i_rst || obs.soft_reset) begin
            cycles <= '0;
        end else if (obs.enable_pc) begin
            cycles <= cycles + 1'b1;
        end
    end

    // Report word mux, registered.
    always_ff @(posedge i_clock) begin
        case (i_sel)
            SEL_PC:       o_word <= pc_word;
            SEL_PC_PLUS4: o_word <= pc_word + word_t'(4);
            SEL_CYCLES:   o_word <= cycles;
            SEL_INSTR:    o_word <= obs.instruction;
            default:      o_word <= '0;
        endcase
    end

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps

`include "mips_debug_config.svh"

module uart_rx (
    input  logic                  i_clock,
    input  logic                  i_rst,
    input  logic                  i_tick,
    input  logic                  i_bit_rx,
    output logic                  o_rx_done,  // Pulse, middle of first stop bit.
    output mips_debug_pkg::byte_t o_data
);
    import mips_debug_pkg::*;

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(`UART_DATA_BITS);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e         state;
    logic [1:0]        sync;      // Two-flop synchronizer.
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    byte_t             shift;
    logic              line;

    assign line   = sync[1];
    assign o_data = shift;        // Stable from done until the next frame's data.

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            sync      <= 2'b11;   // Idle line.
            state     <= RX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_rx_done <= 1'b0;
        end else begin
            sync      <= {sync[0], i_bit_rx};
            o_rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!line) state <= RX_START;  // Falling edge.
                end
                RX_START: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == TICK_W'(`UART_OVERSAMPLE / 2 - 1)) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= line ? RX_IDLE : RX_DATA;  // Glitch rejected.
                    end
                end
                RX_DATA: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1)) begin
                        shift   <= {line, shift[7:1]};   // LSB arrives first.
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(`UART_DATA_BITS - 1)) state <= RX_STOP;
                    end
                end
                RX_STOP: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1)) begin
                        o_rx_done <= line;     // Framing error drops the byte.
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps

`include "mips_debug_config.svh"

module uart_tx (
    input  logic                  i_clock,
    input  logic                  i_rst,
    input  logic                  i_tick,
    input  logic                  i_tx_start,  // Only while idle.
    input  mips_debug_pkg::byte_t i_data,
    output logic                  o_bit_tx,
    output logic                  o_tx_done    // Pulse after last stop bit.
);
    import mips_debug_pkg::*;

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(`UART_DATA_BITS);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e         state;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_cnt;   // Data bits, then stop bits.
    byte_t             shift;
    logic              bit_end;

    assign bit_end = i_tick && (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1));

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state     <= TX_IDLE;
            o_bit_tx  <= 1'b1;     // Line idles high.
            o_tx_done <= 1'b0;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
        end else begin
            o_tx_done <= 1'b0;
            if (i_tick) tick_cnt <= tick_cnt + 1'b1;
            case (state)
                TX_IDLE: if (i_tx_start) begin
                    shift    <= i_data;
                    o_bit_tx <= 1'b0;  // Start bit.
                    tick_cnt <= '0;
                    state    <= TX_START;
                end
                TX_START: if (bit_end) begin
                    o_bit_tx <= shift[0];
                    bit_cnt  <= '0;
                    state    <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    shift    <= {1'b1, shift[7:1]};
                    o_bit_tx <= shift[1];
                    bit_cnt  <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_W'(`UART_DATA_BITS - 1)) begin
                        o_bit_tx <= 1'b1;  // First stop bit.
                        bit_cnt  <= '0;
                        state    <= TX_STOP;
                    end
                end
                TX_STOP: if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_W'(`UART_STOP_BITS - 1)) begin
                        o_tx_done <= 1'b1;
                        state     <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Debug unit must wait for done before the next byte.
    a_start_when_idle: assert property (@(posedge i_clock) disable iff (i_rst)
        i_tx_start |-> state == TX_IDLE);

endmodule

// ==== mips_debug_top.f ====
+incdir+hw
+incdir+tests
hw/mips_debug_pkg.sv
hw/fetch_ctrl_if.sv
hw/baud_rate_generator.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/instruction_fetch.sv
hw/run_status.sv
hw/debug_unit.sv
hw/mips_debug_top.sv
tests/tb_mips_debug_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mips_debug_top \
    -f mips_debug_top.f

# Result comes from the simulation output.
if ./obj_dir/Vtb_mips_debug_top | tee /dev/stderr | grep -qF "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== tests/uart_bfm.svh ====
`ifndef UART_BFM_SVH
`define UART_BFM_SVH

// Host side of the serial link. Uses clock, rx_line, tx_line, report
// and BIT_CYCLES from the including module.

// One frame into the DUT, LSB first.
task automatic send_byte(input byte_t data);
    int i;
    @(negedge clock);
    rx_line = 1'b0;                              // Start bit.
    repeat (BIT_CYCLES) @(negedge clock);
    for (i = 0; i < `UART_DATA_BITS; i++) begin
        rx_line = data[i];
        repeat (BIT_CYCLES) @(negedge clock);
    end
    rx_line = 1'b1;                              // Stop bits, line back to idle.
    repeat (`UART_STOP_BITS * BIT_CYCLES) @(negedge clock);
endtask

// One frame out of the DUT. Returns in the middle of the first stop bit.
task automatic recv_byte(output byte_t data);
    int i;
    data = '0;
    while (tx_line !== 1'b0) @(negedge clock);   // Wait for the start edge.
    repeat (BIT_CYCLES / 2) @(negedge clock);    // Middle of start bit.
    assert (tx_line === 1'b0) else
        fail_run("Start bit on o_uart_tx ended before mid-bit.");
    for (i = 0; i < `UART_DATA_BITS; i++) begin
        repeat (BIT_CYCLES) @(negedge clock);
        data[i] = tx_line;
    end
    repeat (BIT_CYCLES) @(negedge clock);
    assert (tx_line === 1'b1) else
        fail_run("Stop bit on o_uart_tx was low.");
endtask

// Four report words, each LSB first.
task automatic recv_report();
    int w;
    int b;
    byte_t data;
    for (w = 0; w < `REPORT_WORDS; w++) begin
        for (b = 0; b < 4; b++) begin
            recv_byte(data);
            report[w][8*b +: 8] = data;
        end
    end
endtask

`endif

// ==== tests/tb_mips_debug_top.sv ====
`timescale 1ns/1ps

`include "mips_debug_config.svh"

module tb_mips_debug_top;
    import mips_debug_pkg::*;

    localparam int CLK_NS     = 20;
    localparam int BIT_CYCLES = (`CLK_FREQ_HZ / (`BAUD_RATE * `UART_OVERSAMPLE))
                                * `UART_OVERSAMPLE;    // Clocks per serial bit.
    localparam int PROGRAMS   = 3;
    localparam int MAX_N      = 20;

    // Worst case frames per program. Load, steps, run, three more steps, two bare bytes.
    localparam longint FRAMES   = PROGRAMS * (3 + 4 * MAX_N + 17 * (MAX_N - 1) + 4 * 17 + 2);
    localparam longint FRAME_NS = longint'(1 + `UART_DATA_BITS + `UART_STOP_BITS)
                                  * BIT_CYCLES * CLK_NS;
    localparam longint WATCHDOG_NS = 2 * FRAMES * FRAME_NS;

    logic   clock   = 1'b0;
    logic   rst     = 1'b1;
    logic   rx_line = 1'b1;   // Host to DUT, idles high.
    logic   tx_line;
    logic   led_halt;
    integer seed    = 32'hc961;
    string  test_name;

    // Model state.
    word_t model_mem [`PROG_DEPTH];
    int    model_pc;          // Byte address.
    word_t model_cycles;
    logic  model_led;
    word_t report [`REPORT_WORDS];
    byte_t reply_byte;

    always #(CLK_NS / 2) clock = ~clock;

    mips_debug_top DUT (
        .i_clock    (clock),
        .i_rst      (rst),
        .i_uart_rx  (rx_line),
        .o_uart_tx  (tx_line),
        .o_led_halt (led_halt)
    );

    `include "uart_bfm.svh"

    //////////////////////////////////////////////////////////////////////
    // Checks.
    //////////////////////////////////////////////////////////////////////
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped.");
    endtask

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        assert (actual === expected) else
            fail_run($sformatf("Error: %s, %s: expected %08h, actual %08h",
                               test_name, what, expected, actual));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Model of fetch, cycle count and halt LED.
    //////////////////////////////////////////////////////////////////////
    function automatic logic at_halt();
        return model_mem[model_pc / 4][`INSTR_W-1 -: 6] == `HALT_OPCODE;
    endfunction

    task automatic model_clear();
        model_pc     = 0;
        model_cycles = '0;
        model_led    = 1'b0;
    endtask

    task automatic model_step();
        if (at_halt()) begin
            model_led = 1'b1;                 // PC holds on a halt.
        end else begin
            model_pc     = model_pc + 4;
            model_cycles = model_cycles + 1;
        end
    endtask

    task automatic model_run();
        while (!at_halt()) begin
            model_pc     = model_pc + 4;
            model_cycles = model_cycles + 1;
        end
        model_led = 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host commands.
    //////////////////////////////////////////////////////////////////////
    task automatic send_program(input int n);
        int k;
        int b;
        send_byte(CMD_LOAD);
        send_byte(byte_t'(n));                 // Word count.
        for (k = 0; k < n; k++) begin
            for (b = 0; b < 4; b++) send_byte(model_mem[k][8*b +: 8]);
        end
    endtask

    // Random program, halt opcode only at index h.
    task automatic load_program(input int n, input int h);
        int k;
        for (k = 0; k < n; k++) begin
            model_mem[k] = $random(seed);
            if (k == h) begin
                model_mem[k][`INSTR_W-1 -: 6] = `HALT_OPCODE;
            end else if (model_mem[k][`INSTR_W-1 -: 6] == `HALT_OPCODE) begin
                model_mem[k][`INSTR_W-6] = 1'b0;   // Opcode 3e instead.
            end
        end
        fork
            send_program(n);
            recv_byte(reply_byte);              // Reply starts during the last frame.
        join
        model_clear();
        check_value("load reply", word_t'(n), word_t'(reply_byte));
    endtask

    // Report may start before the command's stop bits end.
    task automatic report_command(input byte_t cmd);
        fork
            send_byte(cmd);
            recv_report();
        join
        check_value("pc", word_t'(model_pc), report[int'(SEL_PC)]);
        check_value("pc plus 4", word_t'(model_pc + 4), report[int'(SEL_PC_PLUS4)]);
        check_value("cycles", model_cycles, report[int'(SEL_CYCLES)]);
        check_value("instruction", model_mem[model_pc / 4], report[int'(SEL_INSTR)]);
        check_value("halt led", word_t'(model_led), word_t'(led_halt));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence.
    //////////////////////////////////////////////////////////////////////
    initial begin
        int    prog;
        int    n;
        int    h;
        int    steps;
        int    i;
        byte_t junk;
        test_name = "reset";
        repeat (16) begin
            @(negedge clock);
            check_value("tx line", 1, word_t'(tx_line));
            check_value("halt led", 0, word_t'(led_halt));
        end
        rst = 1'b0;
        repeat (100) begin                      // Quiet line after reset.
            @(negedge clock);
            check_value("tx line", 1, word_t'(tx_line));
            check_value("halt led", 0, word_t'(led_halt));
        end
        for (prog = 0; prog < PROGRAMS; prog++) begin
            n = 4 + ($unsigned($random(seed)) % (MAX_N - 3));
            h = $unsigned($random(seed)) % n;
            test_name = $sformatf("load, program %0d", prog);
            load_program(n, h);
            steps = (h == 0) ? 0 : $unsigned($random(seed)) % h;
            test_name = $sformatf("step, program %0d", prog);
            for (i = 0; i < steps; i++) begin
                model_step();
                report_command(CMD_STEP);
            end
            test_name = $sformatf("run, program %0d", prog);
            model_run();
            report_command(CMD_RUN);
            check_value("run pc", word_t'(4 * h), report[int'(SEL_PC)]);
            check_value("run cycles", word_t'(h), report[int'(SEL_CYCLES)]);
            check_value("run halt led", 1, word_t'(led_halt));
            test_name = $sformatf("step at halt, program %0d", prog);
            model_step();
            report_command(CMD_STEP);
            test_name = $sformatf("reset command, program %0d", prog);
            send_byte(CMD_RESET);               // No reply.
            model_clear();
            check_value("halt led", 0, word_t'(led_halt));
            model_step();
            report_command(CMD_STEP);
            test_name = $sformatf("unknown command, program %0d", prog);
            junk = byte_t'($random(seed));
            while (junk >= 8'h01 && junk <= 8'h04) junk = byte_t'($random(seed));
            send_byte(junk);
            model_step();
            report_command(CMD_STEP);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // Watchdog, twice the worst case serial traffic.
    initial begin
        #(WATCHDOG_NS);
        fail_run($sformatf("Timeout after %0d ns, test did not finish.", WATCHDOG_NS));
    end

endmodule
